/* hdl/rv64_mem_pkg.sv */
package rv64_mem_pkg;

  // datapath widths
  localparam int XLEN     = 64;
  localparam int INST_LEN = 32;
  localparam int REG_AW   = 5;
  localparam int CSR_AW   = 12;

  // data RAM depth in 64-bit words, upper address bits wrap
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // access size; doubleword sits at zero so LD can carry the unsigned flag
  // and the all-zero code stays free for NONE
  typedef enum logic [1:0] {
    SIZE_D = 2'b00,
    SIZE_B = 2'b01,
    SIZE_H = 2'b10,
    SIZE_W = 2'b11
  } mem_size_e;

  typedef struct packed {
    logic      is_store;
    logic      is_unsigned;
    mem_size_e size;
  } memop_fields_t;

  // same 4 bits seen as opcode or as decoded fields
  typedef union packed {
    logic [3:0]    raw;
    memop_fields_t f;
  } memop_u;

  // raw operation codes, laid out as {store, unsigned, size}
  localparam logic [3:0] MEMOP_NONE = 4'b0000;
  localparam logic [3:0] MEMOP_LB   = 4'b0001;
  localparam logic [3:0] MEMOP_LH   = 4'b0010;
  localparam logic [3:0] MEMOP_LW   = 4'b0011;
  localparam logic [3:0] MEMOP_LD   = 4'b0100;
  localparam logic [3:0] MEMOP_LBU  = 4'b0101;
  localparam logic [3:0] MEMOP_LHU  = 4'b0110;
  localparam logic [3:0] MEMOP_LWU  = 4'b0111;
  localparam logic [3:0] MEMOP_SD   = 4'b1000;
  localparam logic [3:0] MEMOP_SB   = 4'b1001;
  localparam logic [3:0] MEMOP_SH   = 4'b1010;
  localparam logic [3:0] MEMOP_SW   = 4'b1011;

  // mcause values from the privileged spec
  localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
  localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

  typedef struct packed {
    logic            valid;
    logic [3:0]      cause;
    logic [XLEN-1:0] value;
  } trap_t;

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [INST_LEN-1:0] inst;
    logic [REG_AW-1:0]   rd_idx;
    logic [XLEN-1:0]     rs2_data;
    memop_u              mem_op;
    logic [XLEN-1:0]     alu_data;
    logic [CSR_AW-1:0]   csr_addr;
    logic [XLEN-1:0]     csr_data;
    logic                csr_valid;
    trap_t               trap;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [INST_LEN-1:0] inst;
    logic [REG_AW-1:0]   rd_idx;
    logic [XLEN-1:0]     mem_data;
    logic [CSR_AW-1:0]   csr_addr;
    logic [XLEN-1:0]     csr_data;
    logic                csr_valid;
    trap_t               trap;
  } mem_wb_t;

  // one request to the data RAM
  typedef struct packed {
    logic [DMEM_AW-1:0] idx;
    logic [XLEN-1:0]    wdata;
    logic [7:0]         wmask;
    logic               write;
  } dmem_req_t;

endpackage

/* hdl/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align import rv64_mem_pkg::*; (
  input  memop_u          op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] store_data_i,
  input  logic [XLEN-1:0] read_word_i,
  output logic [XLEN-1:0] wdata_o,
  output logic [7:0]      wmask_o,
  output logic [XLEN-1:0] load_data_o,
  output logic            misaligned_o
);

  logic [2:0]      ofs;
  logic [7:0]      size_mask;
  logic [2:0]      align_bits;
  logic [XLEN-1:0] read_shifted;
  logic            ext_b;
  logic            ext_h;
  logic            ext_w;

  assign ofs = addr_i[2:0];

  // lane mask and the offset bits that must be zero
  always_comb begin
    unique case (op_i.f.size)
      SIZE_B: begin
        size_mask  = 8'h01;
        align_bits = 3'b000;
      end
      SIZE_H: begin
        size_mask  = 8'h03;
        align_bits = 3'b001;
      end
      SIZE_W: begin
        size_mask  = 8'h0f;
        align_bits = 3'b011;
      end
      default: begin
        size_mask  = 8'hff;
        align_bits = 3'b111;
      end
    endcase
  end

  // store side, move low bytes up to the addressed lanes
  assign wdata_o = store_data_i << {ofs, 3'b000};
  assign wmask_o = op_i.f.is_store ? (size_mask << ofs) : 8'h00;

  // load side, bring addressed bytes down to bit 0
  assign read_shifted = read_word_i >> {ofs, 3'b000};

  assign ext_b = ~op_i.f.is_unsigned & read_shifted[7];
  assign ext_h = ~op_i.f.is_unsigned & read_shifted[15];
  assign ext_w = ~op_i.f.is_unsigned & read_shifted[31];

  always_comb begin
    unique case (op_i.f.size)
      SIZE_B:  load_data_o = {{56{ext_b}}, read_shifted[7:0]};
      SIZE_H:  load_data_o = {{48{ext_h}}, read_shifted[15:0]};
      SIZE_W:  load_data_o = {{32{ext_w}}, read_shifted[31:0]};
      default: load_data_o = read_shifted;
    endcase
  end

  // NONE decodes as a doubleword, so keep it out of the check
  assign misaligned_o = (op_i.raw != MEMOP_NONE) && ((ofs & align_bits) != 3'b000);

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram import rv64_mem_pkg::*; (
  input  logic            clk,
  input  logic            rst_i,
  input  dmem_req_t       req_i,
  input  logic            req_valid_i,
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_rdata_o
);

  logic [XLEN-1:0] mem [DMEM_WORDS];

  // byte-masked write, registered read
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        for (int b = 0; b < 8; b++) begin
          if (req_i.wmask[b]) begin
            mem[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rsp_rdata_o <= mem[req_i.idx];
      end
    end
  end

  // one response per request, writes included
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

  // the stage should never send a store that touches no byte
  a_write_mask: assert property (@(posedge clk) disable iff (rst_i)
    (req_valid_i && req_i.write) |-> (req_i.wmask != 8'h00));

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import rv64_mem_pkg::*; (
  input  logic            clk,
  input  logic            rst_i,
  input  ex_mem_t         in_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  output mem_wb_t         out_o,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output dmem_req_t       req_o,
  output logic            req_valid_o,
  input  logic            rsp_valid_i,
  input  logic [XLEN-1:0] rsp_rdata_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_OUT
  } state_e;

  state_e          state_q;
  ex_mem_t         held_q;
  mem_wb_t         out_q;
  ex_mem_t         cur_item;
  logic            accept;
  logic            in_is_mem;
  logic            held_is_load;
  logic            misaligned;
  logic            new_trap;
  logic [XLEN-1:0] wdata;
  logic [7:0]      wmask;
  logic [XLEN-1:0] load_data;

  assign accept = in_valid_i && (state_q == S_IDLE);

  // alignment unit looks at the incoming item while idle, else the held one
  assign cur_item = (state_q == S_IDLE) ? in_i : held_q;

  lsu_align u_align (
    .op_i         (cur_item.mem_op),
    .addr_i       (cur_item.alu_data),
    .store_data_i (cur_item.rs2_data),
    .read_word_i  (rsp_rdata_i),
    .wdata_o      (wdata),
    .wmask_o      (wmask),
    .load_data_o  (load_data),
    .misaligned_o (misaligned)
  );

  assign in_is_mem    = in_i.mem_op.raw != MEMOP_NONE;
  assign held_is_load = (held_q.mem_op.raw != MEMOP_NONE) && !held_q.mem_op.f.is_store;

  // an earlier trap wins over a misalignment found here
  assign new_trap = misaligned && !in_i.trap.valid;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (in_valid_i) begin
            // items that skip memory go straight to the output
            if (!in_is_mem || in_i.trap.valid || misaligned) begin
              state_q <= S_OUT;
            end else begin
              state_q <= S_REQ;
            end
          end
        end
        S_REQ: begin
          state_q <= S_WAIT;
        end
        S_WAIT: begin
          if (rsp_valid_i) begin
            state_q <= S_OUT;
          end
        end
        S_OUT: begin
          if (out_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_q           <= in_i;
      out_q.pc         <= in_i.pc;
      out_q.inst       <= in_i.inst;
      out_q.rd_idx     <= in_i.rd_idx;
      out_q.csr_addr   <= in_i.csr_addr;
      out_q.csr_data   <= in_i.csr_data;
      out_q.csr_valid  <= in_i.csr_valid;
      out_q.mem_data   <= in_i.alu_data;
      out_q.trap       <= in_i.trap;
      if (new_trap) begin
        out_q.trap.valid <= 1'b1;
        out_q.trap.cause <= in_i.mem_op.f.is_store ? CAUSE_STORE_MISALIGNED
                                                   : CAUSE_LOAD_MISALIGNED;
        out_q.trap.value <= in_i.alu_data;
      end
    end
    // load result replaces the alu value
    if ((state_q == S_WAIT) && rsp_valid_i && held_is_load) begin
      out_q.mem_data <= load_data;
    end
  end

  assign in_ready_o  = (state_q == S_IDLE);
  assign out_valid_o = (state_q == S_OUT);
  assign out_o       = out_q;

  // request built from the held item
  assign req_valid_o   = (state_q == S_REQ);
  assign req_o.idx     = held_q.alu_data[3 +: DMEM_AW];
  assign req_o.wdata   = wdata;
  assign req_o.wmask   = wmask;
  assign req_o.write   = held_q.mem_op.f.is_store;

  // RAM answers next cycle, and no second request overlaps it
  a_req_rsp: assert property (@(posedge clk) disable iff (rst_i)
    req_valid_o |=> (rsp_valid_i && !req_valid_o));

  // output held steady under back-pressure
  a_out_stable: assert property (@(posedge clk) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)));

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import rv64_mem_pkg::*; (
  input  logic    clk,
  input  logic    rst_i,
  input  ex_mem_t in_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  output mem_wb_t out_o,
  output logic    out_valid_o,
  input  logic    out_ready_i
);

  dmem_req_t       dmem_req;
  logic            dmem_req_valid;
  logic            dmem_rsp_valid;
  logic [XLEN-1:0] dmem_rsp_rdata;

  mem_stage u_mem_stage (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_i        (in_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_o       (out_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .req_o       (dmem_req),
    .req_valid_o (dmem_req_valid),
    .rsp_valid_i (dmem_rsp_valid),
    .rsp_rdata_i (dmem_rsp_rdata)
  );

  // on-chip data memory
  data_ram u_data_ram (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (dmem_req),
    .req_valid_i (dmem_req_valid),
    .rsp_valid_o (dmem_rsp_valid),
    .rsp_rdata_o (dmem_rsp_rdata)
  );

endmodule

/* tb/tb_mem_tasks.svh */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

// bytes touched by an operation code
function automatic int op_bytes(input logic [3:0] op);
  case (op)
    MEMOP_LB, MEMOP_LBU, MEMOP_SB: return 1;
    MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 2;
    MEMOP_LW, MEMOP_LWU, MEMOP_SW: return 4;
    default: return 8;
  endcase
endfunction

function automatic void model_store(input logic [63:0] addr, input int n,
                                    input logic [63:0] data);
  logic [10:0] a;
  for (int i = 0; i < n; i++) begin
    a = addr[10:0] + 11'(i);
    model_mem[a] = data[8*i +: 8];
  end
endfunction

function automatic logic [63:0] model_load(input logic [3:0] op, input logic [63:0] addr);
  logic [63:0] v;
  logic [10:0] a;
  int          n;
  n = op_bytes(op);
  v = '0;
  for (int i = 0; i < n; i++) begin
    a = addr[10:0] + 11'(i);
    v[8*i +: 8] = model_mem[a];
  end
  // sign extension from the top loaded byte
  if (!(op inside {MEMOP_LBU, MEMOP_LHU, MEMOP_LWU}) && n < 8 && v[8*n-1]) begin
    v = v | (64'hffff_ffff_ffff_ffff << (8*n));
  end
  return v;
endfunction

task automatic send_item(input ex_mem_t item);
  @(posedge clk);
  in_i       <= item;
  in_valid_i <= 1'b1;
  @(negedge clk);
  while (!in_ready_o) @(negedge clk);
  @(posedge clk);
  in_valid_i <= 1'b0;
endtask

// hold keeps out_ready_i low for that many cycles once the result shows up
task automatic get_item(input string name, input int hold, output mem_wb_t res);
  @(negedge clk);
  while (!out_valid_o) @(negedge clk);
  res = out_o;
  repeat (hold) begin
    @(negedge clk);
    assert (out_valid_o && (out_o === res)) else begin
      $display("test %s: output dropped or changed while out_ready_i was low", name);
      err_cnt++;
    end
    assert (!in_ready_o) else begin
      $display("test %s: stage ready for input while holding a result", name);
      err_cnt++;
    end
  end
  @(posedge clk);
  out_ready_i <= 1'b1;
  @(posedge clk);
  out_ready_i <= 1'b0;
  @(negedge clk);
  assert (!out_valid_o) else begin
    $display("test %s: result still valid after it was taken", name);
    err_cnt++;
  end
endtask

task automatic run_op(input string name, input logic [3:0] op, input logic [63:0] addr,
                      input logic [63:0] data, input trap_t in_trap, input int hold);
  ex_mem_t item;
  mem_wb_t exp_wb;
  mem_wb_t act_wb;
  int      n;
  logic    is_store;
  n              = op_bytes(op);
  is_store       = op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};
  item.pc        = rand_bits(64);
  item.inst      = 32'(rand_bits(32));
  item.rd_idx    = 5'(rand_bits(5));
  item.rs2_data  = data;
  item.mem_op    = op;
  item.alu_data  = addr;
  item.csr_addr  = 12'(rand_bits(12));
  item.csr_data  = rand_bits(64);
  item.csr_valid = 1'(rand_bits(1));
  item.trap      = in_trap;
  exp_wb.pc        = item.pc;
  exp_wb.inst      = item.inst;
  exp_wb.rd_idx    = item.rd_idx;
  exp_wb.mem_data  = addr;
  exp_wb.csr_addr  = item.csr_addr;
  exp_wb.csr_data  = item.csr_data;
  exp_wb.csr_valid = item.csr_valid;
  exp_wb.trap      = in_trap;
  // an incoming trap or a non-memory op skips the RAM
  if (!in_trap.valid && op != MEMOP_NONE) begin
    if ((addr[2:0] & 3'(n - 1)) != 3'b000) begin
      exp_wb.trap.valid = 1'b1;
      exp_wb.trap.cause = is_store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
      exp_wb.trap.value = addr;
    end else if (is_store) begin
      model_store(addr, n, data);
    end else begin
      exp_wb.mem_data = model_load(op, addr);
    end
  end
  send_item(item);
  get_item(name, hold, act_wb);
  check_val(name, "mem_data", 320'(exp_wb.mem_data), 320'(act_wb.mem_data));
  check_val(name, "trap", 320'(exp_wb.trap), 320'(act_wb.trap));
  check_val(name, "record", 320'(exp_wb), 320'(act_wb));
endtask

task automatic non_mem_passthrough();
  int e0;
  e0 = err_cnt;
  @(negedge clk);
  check_val("non_mem", "in_ready/out_valid after reset", 320'(2'b10),
            320'({in_ready_o, out_valid_o}));
  repeat (4) run_op("non_mem", MEMOP_NONE, rand_bits(64), rand_bits(64), '0, 0);
  report_test("non_mem", e0);
endtask

task automatic load_sizes_and_signs();
  logic [3:0]  load_ops [7];
  logic [63:0] base;
  logic [63:0] word;
  int          e0;
  int          n;
  load_ops = '{MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW, MEMOP_LWU, MEMOP_LD};
  e0 = err_cnt;
  base = rand_addr();
  word = rand_bits(64);
  // second pass with the complement flips every sign bit
  for (int pass = 0; pass < 2; pass++) begin
    run_op("load_sizes", MEMOP_SD, base, (pass == 0) ? word : ~word, '0, 0);
    foreach (load_ops[k]) begin
      n = op_bytes(load_ops[k]);
      for (int ofs = 0; ofs < 8; ofs += n) begin
        run_op("load_sizes", load_ops[k], base + 64'(ofs), 64'd0, '0, 0);
      end
    end
  end
  report_test("load_sizes", e0);
endtask

task automatic subword_store_lanes();
  logic [63:0] base;
  int          e0;
  e0 = err_cnt;
  base = rand_addr();
  run_op("subword_store", MEMOP_SD, base, rand_bits(64), '0, 0);
  run_op("subword_store", MEMOP_SB, base + 64'd3, rand_bits(64), '0, 0);
  run_op("subword_store", MEMOP_SH, base + 64'd6, rand_bits(64), '0, 0);
  run_op("subword_store", MEMOP_LD, base, 64'd0, '0, 0);
  run_op("subword_store", MEMOP_SW, base, rand_bits(64), '0, 0);
  run_op("subword_store", MEMOP_LD, base, 64'd0, '0, 0);
  report_test("subword_store", e0);
endtask

task automatic misaligned_traps();
  logic [63:0] base;
  int          e0;
  e0 = err_cnt;
  base = rand_addr();
  run_op("misaligned", MEMOP_SD, base, rand_bits(64), '0, 0);
  run_op("misaligned", MEMOP_LH, base + 64'd1, 64'd0, '0, 0);
  run_op("misaligned", MEMOP_SH, base + 64'd3, rand_bits(64), '0, 0);
  run_op("misaligned", MEMOP_LW, base + 64'd2, 64'd0, '0, 0);
  run_op("misaligned", MEMOP_SW, base + 64'd6, rand_bits(64), '0, 0);
  run_op("misaligned", MEMOP_LD, base + 64'd4, 64'd0, '0, 0);
  run_op("misaligned", MEMOP_SD, base + 64'd5, rand_bits(64), '0, 0);
  run_op("misaligned", MEMOP_LD, base, 64'd0, '0, 0);
  report_test("misaligned", e0);
endtask

task automatic incoming_trap_passthrough();
  trap_t       t;
  logic [63:0] base;
  int          e0;
  e0 = err_cnt;
  t.valid = 1'b1;
  t.cause = 4'(rand_bits(4));
  t.value = rand_bits(64);
  base = rand_addr();
  run_op("incoming_trap", MEMOP_SD, base, rand_bits(64), '0, 0);
  run_op("incoming_trap", MEMOP_SD, base, rand_bits(64), t, 0);
  run_op("incoming_trap", MEMOP_SB, base + 64'd1, rand_bits(64), t, 0);
  // misaligned as well, the earlier trap still wins
  run_op("incoming_trap", MEMOP_LH, base + 64'd1, 64'd0, t, 0);
  run_op("incoming_trap", MEMOP_NONE, rand_bits(64), rand_bits(64), t, 0);
  run_op("incoming_trap", MEMOP_LD, base, 64'd0, '0, 0);
  report_test("incoming_trap", e0);
endtask

task automatic output_backpressure();
  logic [63:0] base;
  int          e0;
  e0 = err_cnt;
  base = rand_addr();
  run_op("backpressure", MEMOP_SD, base, rand_bits(64), '0, 6);
  run_op("backpressure", MEMOP_LD, base, 64'd0, '0, 6);
  run_op("backpressure", MEMOP_NONE, rand_bits(64), rand_bits(64), '0, 3);
  report_test("backpressure", e0);
endtask

`endif

/* tb/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys import rv64_mem_pkg::*; ();

  localparam int CYCLE_LIMIT = 4000;

  logic    clk;
  logic    rst_i;
  ex_mem_t in_i;
  logic    in_valid_i;
  logic    in_ready_o;
  mem_wb_t out_o;
  logic    out_valid_o;
  logic    out_ready_i;

  logic [15:0] lfsr_state;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          cycle_cnt;

  // byte image of the RAM, indexed by the low 11 address bits
  logic [7:0] model_mem [DMEM_WORDS*8];

  mem_subsys_top UUT (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_i        (in_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_o       (out_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  always #20 clk = ~clk;

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  // doubleword aligned, random upper bits exercise the index wrap
  function automatic logic [63:0] rand_addr();
    return {53'(rand_bits(53)), 8'(rand_bits(8)), 3'b000};
  endfunction

  task automatic check_val(input string name, input string what,
                           input logic [319:0] exp_v, input logic [319:0] act_v);
    assert (act_v === exp_v) else begin
      $display("CHECK FAILED %s %s expected %0h actual %0h", name, what, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    if (err_cnt != e0) begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - e0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  `include "tb_mem_tasks.svh"

  // run limit, roughly ten times the expected length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    clk          = 1'b0;
    rst_i        = 1'b1;
    in_i         = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b0;
    lfsr_state   = 16'd23683;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;

    non_mem_passthrough();
    load_sizes_and_signs();
    subword_store_lanes();
    misaligned_traps();
    incoming_trap_passthrough();
    output_backpressure();

    $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+tb
hdl/rv64_mem_pkg.sv
hdl/lsu_align.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mem_subsys
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
